/* verilog.f */
+incdir+logic
logic/rv_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/commit_stage.sv
logic/rv_core.sv
dv/tb_mem_model.sv
dv/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# compiles the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f verilog.f --top-module tb_rv_core

status=0
./obj_dir/Vtb_rv_core > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then
	echo "run.sh: simulation reported failure"
	exit 1
fi
echo "run.sh: simulation ok"

/* dv/tb_rv_core.sv */
// program lives in 4 KB of code; result slots start at 0x400, the load word sits at 0x100
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_rv_core;

	localparam int MEM_WORDS = 1024;
	localparam int MAX_ST    = 256;
	localparam int TIMEOUT   = 20000; // cycles for all stores

	logic          clk;
	logic          rstn;
	rv_pkg::word_t insn_adrs;
	rv_pkg::insn_t insn_rdata;
	rv_pkg::word_t data_adrs;
	rv_pkg::word_t data_wdata;
	logic          data_load;
	logic          data_store;
	rv_pkg::strb_t data_wstrb;
	rv_pkg::word_t data_rdata;
	int            store_cnt;

	rv_pkg::insn_t code [MEM_WORDS];
	rv_pkg::word_t data_init [MEM_WORDS];
	logic [7:0]    ref_mem [4*MEM_WORDS]; // byte image for load rules
	rv_pkg::word_t xr [32];               // register model
	rv_pkg::word_t exp_adrs [MAX_ST];
	rv_pkg::word_t exp_data [MAX_ST];
	rv_pkg::strb_t exp_strb [MAX_ST];
	int            n_exp;
	int            slot;
	int            err_cnt = 0;
	int            to_cnt  = 0;
	rv_pkg::word_t pc;
	logic [7:0]    cur;
	rv_pkg::word_t lane_mask;

	rv_core u_rv_core (
		.clk(clk), .rstn(rstn), .insn_adrs(insn_adrs), .insn_rdata(insn_rdata),
		.data_adrs(data_adrs), .data_wdata(data_wdata), .data_load(data_load),
		.data_store(data_store), .data_wstrb(data_wstrb), .data_rdata(data_rdata)
	);

	tb_mem_model #(.WORDS(MEM_WORDS)) u_mem (
		.clk(clk), .rstn(rstn), .code(code), .data_init(data_init),
		.insn_adrs(insn_adrs), .insn_rdata(insn_rdata), .data_adrs(data_adrs),
		.data_wdata(data_wdata), .data_store(data_store), .data_wstrb(data_wstrb),
		.data_rdata(data_rdata), .store_cnt(store_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns
	end

	// ------------------------------------------------------------------
	// ISA rules and program assembly
	// ------------------------------------------------------------------
	function automatic rv_pkg::word_t sext12(input logic [11:0] imm);
		return {{20{imm[11]}}, imm};
	endfunction

	function automatic rv_pkg::word_t alu_rule(input logic [2:0] f3, input logic alt,
		input rv_pkg::word_t a, input rv_pkg::word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_rule(input logic [2:0] f3, input rv_pkg::word_t a,
		input rv_pkg::word_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic emit(input rv_pkg::insn_t insn);
		code[pc[11:2]] = insn;
		pc = pc + 4;
	endtask

	task automatic write_reg(input logic [4:0] rd, input rv_pkg::word_t v);
		if (rd != 5'd0)
			xr[rd] = v; // x0 stays zero
	endtask

	task automatic expect_store(input rv_pkg::word_t adrs, input rv_pkg::word_t data,
		input rv_pkg::strb_t strb);
		exp_adrs[n_exp[7:0]] = adrs;
		exp_data[n_exp[7:0]] = data;
		exp_strb[n_exp[7:0]] = strb;
		n_exp++;
	endtask

	task automatic alu_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		write_reg(rd, alu_rule(f3, f3 == 3'd5 && imm[10], xr[rs1], sext12(imm)));
		emit({imm, rs1, f3, rd, `RV_OPC_OP_IMM});
	endtask

	task automatic alu_reg(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		write_reg(rd, alu_rule(f3, alt, xr[rs1], xr[rs2]));
		emit({1'b0, alt, 5'd0, rs2, rs1, f3, rd, `RV_OPC_OP});
	endtask

	task automatic load_upper(input logic [4:0] rd, input logic [19:0] imm);
		write_reg(rd, {imm, 12'h000});
		emit({imm, rd, `RV_OPC_LUI});
	endtask

	task automatic add_upper_pc(input logic [4:0] rd, input logic [19:0] imm);
		write_reg(rd, pc + {imm, 12'h000});
		emit({imm, rd, `RV_OPC_AUIPC});
	endtask

	// lui then addi, the upper part rounded for the signed low part
	task automatic set_reg(input logic [4:0] rd, input rv_pkg::word_t val);
		rv_pkg::word_t t;
		t = val + 32'h800;
		load_upper(rd, t[31:12]);
		alu_imm(3'd0, rd, rd, val[11:0]);
	endtask

	task automatic store(input logic [2:0] f3, input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] off);
		rv_pkg::word_t adrs;
		rv_pkg::word_t v;
		logic [11:0]   ba;
		int            n;
		adrs = xr[rs1] + sext12(off);
		v    = xr[rs2];
		n    = 1 << f3[1:0]; // bytes written
		emit({off[11:5], rs2, rs1, f3, off[4:0], `RV_OPC_STORE});
		expect_store(adrs, v << {adrs[1:0], 3'b000},
			rv_pkg::strb_t'((1 << n) - 1) << adrs[1:0]);
		for (int i = 0; i < n; i++) begin
			ba          = adrs[11:0] + 12'(i);
			ref_mem[ba] = v[8*i +: 8];
		end
	endtask

	task automatic store_result(input logic [4:0] rs);
		store(3'b010, rs, 5'd31, 12'(slot * 4)); // own word per result
		slot++;
	endtask

	// slot that a taken control transfer must skip
	task automatic skipped_store();
		emit({7'b0111111, 5'd0, 5'd31, 3'b010, 5'b11100, `RV_OPC_STORE}); // 0xbfc
	endtask

	task automatic load(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] off);
		rv_pkg::word_t adrs;
		rv_pkg::word_t w;
		logic [11:0]   ba;
		adrs = xr[rs1] + sext12(off);
		ba   = adrs[11:0];
		w    = {ref_mem[ba + 12'd3], ref_mem[ba + 12'd2], ref_mem[ba + 12'd1], ref_mem[ba]};
		case (f3)
			3'd0: w = {{24{w[7]}}, w[7:0]};   // lb
			3'd4: w = {24'h0, w[7:0]};        // lbu
			3'd1: w = {{16{w[15]}}, w[15:0]}; // lh
			3'd5: w = {16'h0, w[15:0]};       // lhu
			default: ;
		endcase
		write_reg(rd, w);
		emit({off, rs1, f3, rd, `RV_OPC_LOAD});
	endtask

	// always jumps over exactly one slot when taken
	task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
		output logic taken);
		logic [12:0] off;
		off   = 13'd8;
		taken = branch_rule(f3, xr[rs1], xr[rs2]);
		emit({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OPC_BRANCH});
	endtask

	task automatic jump_link(input logic [4:0] rd, input logic [20:0] off);
		write_reg(rd, pc + 4);
		emit({off[20], off[10:1], off[11], off[19:12], rd, `RV_OPC_JAL});
	endtask

	task automatic jump_reg(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] off);
		write_reg(rd, pc + 4);
		emit({off, rs1, 3'b000, rd, `RV_OPC_JALR});
	endtask

	// ------------------------------------------------------------------
	// checks on the data bus
	// ------------------------------------------------------------------
	assign cur = store_cnt[7:0]; // next expected store

	always_comb begin
		for (int b = 0; b < 4; b++)
			lane_mask[8*b +: 8] = {8{exp_strb[cur][b]}};
	end

	a_first_fetch: assert property (@(posedge clk) $rose(rstn) |-> insn_adrs == `RV_RESET_ADDR)
		else begin
			err_cnt++;
			$display("[FAIL] insn_adrs got %h exp %h", $sampled(insn_adrs), `RV_RESET_ADDR);
		end

	a_no_early_load: assert property (@(posedge clk) disable iff (!rstn)
		store_cnt == 0 |-> !data_load)
		else begin
			err_cnt++;
			$display("data load seen before the first store committed");
		end

	a_store_count: assert property (@(posedge clk) disable iff (!rstn)
		data_store |-> store_cnt < n_exp)
		else begin
			err_cnt++;
			$display("store after the last program store at %h", $sampled(data_adrs));
		end

	a_store_adrs: assert property (@(posedge clk) disable iff (!rstn)
		data_store |-> data_adrs == exp_adrs[cur])
		else begin
			err_cnt++;
			$display("[FAIL] data_adrs got %h exp %h", $sampled(data_adrs),
				$sampled(exp_adrs[cur]));
		end

	a_store_strb: assert property (@(posedge clk) disable iff (!rstn)
		data_store |-> data_wstrb == exp_strb[cur])
		else begin
			err_cnt++;
			$display("[FAIL] data_wstrb got %h exp %h", $sampled(data_wstrb),
				$sampled(exp_strb[cur]));
		end

	a_store_data: assert property (@(posedge clk) disable iff (!rstn)
		data_store |-> (data_wdata & lane_mask) == (exp_data[cur] & lane_mask))
		else begin
			err_cnt++;
			$display("[FAIL] data_wdata got %h exp %h mask %h", $sampled(data_wdata),
				$sampled(exp_data[cur]), $sampled(lane_mask));
		end

	// ------------------------------------------------------------------
	// program build, reset and run
	// ------------------------------------------------------------------
	initial begin
		rv_pkg::word_t a;
		rv_pkg::word_t b;
		logic [11:0]   imm;
		logic          taken;
		int            cyc;
		rstn = 1'b0;
		void'($urandom(10637));
		for (int i = 0; i < MEM_WORDS; i++) begin
			code[i[9:0]]      = rv_pkg::insn_t'(i) << 7; // opcode 0, a bubble
			data_init[i[9:0]] = rv_pkg::word_t'(i) * 32'h9E37_79B9;
			for (int k = 0; k < 4; k++)
				ref_mem[{i[9:0], k[1:0]}] = data_init[i[9:0]][8*k +: 8];
		end
		for (int r = 0; r < 32; r++)
			xr[r[4:0]] = '0;
		pc    = `RV_RESET_ADDR;
		n_exp = 0;
		slot  = 0;

		alu_imm(3'd0, 31, 0, 12'h400); // result base
		alu_imm(3'd0, 30, 0, 12'h100); // load word base
		set_reg(1, $urandom());
		set_reg(2, $urandom());
		for (int f = 0; f < 8; f++) begin
			imm = 12'($urandom());
			if (f == 1 || f == 5)
				imm = imm & 12'h01F; // slli, srli
			alu_imm(3'(f), 4, 1, imm);
			store_result(4);
			alu_reg(3'(f), 1'b0, 4, 1, 2);
			store_result(4);
		end
		alu_imm(3'd5, 4, 1, 12'h400 | (12'($urandom()) & 12'h01F)); // srai
		store_result(4);
		alu_reg(3'd0, 1'b1, 4, 1, 2); // sub
		store_result(4);
		alu_reg(3'd5, 1'b1, 4, 2, 1); // sra
		store_result(4);
		load_upper(5, 20'($urandom()));
		store_result(5);
		add_upper_pc(5, 20'($urandom()));
		store_result(5);

		// back-to-back chain through the bypass and the stall
		alu_imm(3'd0, 6, 1, 12'($urandom()));
		alu_reg(3'd0, 1'b0, 6, 6, 2);
		alu_reg(3'd4, 1'b0, 6, 6, 1);
		alu_reg(3'd0, 1'b1, 6, 6, 2);
		store_result(6);

		// loads at every legal offset of one word
		set_reg(7, $urandom() | 32'h8000_0080);
		store(3'b010, 7, 30, 12'h000);
		for (int o = 0; o < 4; o++) begin
			load(3'd0, 8, 30, 12'(o));
			store_result(8);
			load(3'd4, 8, 30, 12'(o));
			store_result(8);
		end
		for (int o = 0; o < 4; o += 2) begin
			load(3'd1, 8, 30, 12'(o));
			store_result(8);
			load(3'd5, 8, 30, 12'(o));
			store_result(8);
		end
		load(3'd2, 9, 30, 12'h000);
		alu_reg(3'd0, 1'b0, 10, 9, 1); // load-use
		store_result(10);
		load(3'd2, 9, 0, 12'h200);     // untouched fill word
		store_result(9);

		// stores at every legal offset
		for (int o = 0; o < 4; o++) begin
			store(3'b000, 1, 31, 12'(slot * 4 + o));
			slot++;
		end
		for (int o = 0; o < 4; o += 2) begin
			store(3'b001, 1, 31, 12'(slot * 4 + o));
			slot++;
		end
		store_result(1);

		// branches, each with random, equal and sign-flipped operands
		for (int f = 0; f < 8; f++) begin
			if (f == 2 || f == 3)
				continue;
			for (int v = 0; v < 3; v++) begin
				a = $urandom();
				b = (v == 0) ? $urandom() : (v == 1) ? a : a ^ 32'h8000_0000;
				set_reg(11, a);
				set_reg(12, b);
				branch(3'(f), 11, 12, taken);
				if (taken)
					skipped_store();
				else
					store_result(11);
			end
		end
		jump_link(13, 21'd12);
		skipped_store();
		skipped_store();
		store_result(13);
		add_upper_pc(14, 20'h0);
		jump_reg(15, 14, 12'd16); // lands two slots past itself
		skipped_store();
		skipped_store();
		store_result(15);
		jump_link(0, 21'd0);      // park

		repeat (5) @(negedge clk);
		rstn = 1'b1;

		cyc = 0;
		while (store_cnt < n_exp && cyc < TIMEOUT) begin
			@(negedge clk);
			cyc++;
		end
		if (store_cnt < n_exp) begin
			to_cnt++;
			$display("timeout: %0d of %0d stores seen", store_cnt, n_exp);
		end
		repeat (16) @(negedge clk); // window for stray stores

		$display("errors: %0d check, %0d timeout, %0d stores", err_cnt, to_cnt, store_cnt);
		if (err_cnt == 0 && to_cnt == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* dv/tb_mem_model.sv */
// code and data are separate WORDS-deep arrays; address bits above the array size are ignored
`timescale 1ns/1ps

module tb_mem_model #(
	parameter int WORDS = 1024
) (
	input  logic          clk,
	input  logic          rstn,
	input  rv_pkg::insn_t code [WORDS],      // program image
	input  rv_pkg::word_t data_init [WORDS], // data loaded during reset
	input  rv_pkg::word_t insn_adrs,
	output rv_pkg::insn_t insn_rdata,
	input  rv_pkg::word_t data_adrs,
	input  rv_pkg::word_t data_wdata,
	input  logic          data_store,
	input  rv_pkg::strb_t data_wstrb,
	output rv_pkg::word_t data_rdata,
	output int            store_cnt          // stores written so far
);

	localparam int AW = $clog2(WORDS);

	rv_pkg::word_t data [WORDS];
	logic [AW-1:0] code_idx;
	logic [AW-1:0] data_idx;

	assign code_idx   = insn_adrs[AW+1:2];
	assign data_idx   = data_adrs[AW+1:2];
	assign insn_rdata = code[code_idx];  // same-cycle read
	assign data_rdata = data[data_idx];

	// ------------------------------------------------------------------
	// byte-strobed write at the edge that ends the store cycle
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < WORDS; i++) begin
				data[i[AW-1:0]] <= data_init[i[AW-1:0]];
			end
			store_cnt <= 0;
		end else if (data_store) begin
			for (int b = 0; b < $bits(rv_pkg::strb_t); b++) begin
				if (data_wstrb[b])
					data[data_idx][8*b +: 8] <= data_wdata[8*b +: 8];
			end
			store_cnt <= store_cnt + 1; // one count per store
		end
	end

endmodule

/* logic/rv_core.sv */
// fixed-latency buses, no wait states; stores land at the edge after data_store
`timescale 1ns/1ps

module rv_core (
	input  logic          clk,
	input  logic          rstn,
	output rv_pkg::word_t insn_adrs,  // code address
	input  rv_pkg::insn_t insn_rdata, // same cycle
	output rv_pkg::word_t data_adrs,
	output rv_pkg::word_t data_wdata,
	output logic          data_load,
	output logic          data_store,
	output rv_pkg::strb_t data_wstrb,
	input  rv_pkg::word_t data_rdata  // same cycle as data_load
);

	// -----------------------------------------------------------------
	// inter-stage signals
	// -----------------------------------------------------------------
	rv_pkg::fd_pkt_t   fd;
	rv_pkg::de_pkt_t   de;
	rv_pkg::em_pkt_t   em;
	rv_pkg::redirect_t redir;
	logic              stall;
	logic              em_is_load;
	rv_pkg::reg_idx_t  rs1_idx;
	rv_pkg::reg_idx_t  rs2_idx;
	rv_pkg::word_t     rs1_val;
	rv_pkg::word_t     rs2_val;
	rv_pkg::reg_idx_t  byp_rd;
	rv_pkg::word_t     byp_val;

	fetch_stage u_fetch (
		.clk(clk), .rstn(rstn), .stall(stall), .redir(redir),
		.insn_rdata(insn_rdata), .insn_adrs(insn_adrs), .fd(fd)
	);

	decode_stage u_decode (
		.clk(clk), .rstn(rstn), .fd(fd), .redir(redir),
		.rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_val(rs1_val), .rs2_val(rs2_val),
		.byp_rd(byp_rd), .byp_val(byp_val), .em_rd(em.rd), .em_is_load(em_is_load),
		.stall(stall), .de(de)
	);

	execute_stage u_execute (
		.clk(clk), .rstn(rstn), .de(de), .redir(redir), .em(em)
	);

	commit_stage u_commit (
		.clk(clk), .rstn(rstn), .em(em),
		.rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_val(rs1_val), .rs2_val(rs2_val),
		.byp_rd(byp_rd), .byp_val(byp_val), .em_is_load(em_is_load),
		.data_rdata(data_rdata), .data_adrs(data_adrs), .data_wdata(data_wdata),
		.data_load(data_load), .data_store(data_store), .data_wstrb(data_wstrb)
	);

endmodule

/* logic/commit_stage.sv */
// data memory must answer loads in the same cycle; misaligned accesses are not split or trapped
`timescale 1ns/1ps
`include "rv_defines.svh"

module commit_stage (
	input  logic             clk,
	input  logic             rstn,
	input  rv_pkg::em_pkt_t  em,
	input  rv_pkg::reg_idx_t rs1_idx,
	input  rv_pkg::reg_idx_t rs2_idx,
	output rv_pkg::word_t    rs1_val,
	output rv_pkg::word_t    rs2_val,
	output rv_pkg::reg_idx_t byp_rd,   // zero when no bypass
	output rv_pkg::word_t    byp_val,
	output logic             em_is_load,
	input  rv_pkg::word_t    data_rdata,
	output rv_pkg::word_t    data_adrs,
	output rv_pkg::word_t    data_wdata,
	output logic             data_load,
	output logic             data_store,
	output rv_pkg::strb_t    data_wstrb
);

	rv_pkg::word_t regs [`RV_NREGS]; // x0 entry never written
	rv_pkg::strb_t size_mask;
	rv_pkg::word_t ld_shift;
	rv_pkg::word_t ld_val;
	rv_pkg::word_t wb_val;

	// async reads, x0 forced to zero
	assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

	// -----------------------------------------------------------------
	// data bus
	// -----------------------------------------------------------------
	assign data_load  = em.cls == rv_pkg::CLS_LOAD;
	assign data_store = em.cls == rv_pkg::CLS_STORE;
	assign data_adrs  = em.ls_adrs;
	assign data_wdata = em.result;  // already lane-replicated
	assign em_is_load = data_load;

	always_comb begin
		case (em.funct3[1:0])
			2'b00: size_mask = rv_pkg::strb_t'(1);  // byte
			2'b01: size_mask = rv_pkg::strb_t'(3);  // half
			default: size_mask = '1;                // word
		endcase
	end

	assign data_wstrb = data_store ? size_mask << em.ls_adrs[1:0] : '0;

	// load lane select and extension
	assign ld_shift = data_rdata >> {em.ls_adrs[1:0], 3'b000};

	always_comb begin
		case (em.funct3)
			3'b000: ld_val = {{(`RV_XLEN-8){ld_shift[7]}}, ld_shift[7:0]};    // lb
			3'b100: ld_val = {{(`RV_XLEN-8){1'b0}}, ld_shift[7:0]};           // lbu
			3'b001: ld_val = {{(`RV_XLEN-16){ld_shift[15]}}, ld_shift[15:0]}; // lh
			3'b101: ld_val = {{(`RV_XLEN-16){1'b0}}, ld_shift[15:0]};         // lhu
			default: ld_val = ld_shift;                                       // lw
		endcase
	end

	assign wb_val  = data_load ? ld_val : em.result;
	assign byp_rd  = data_load ? '0 : em.rd; // load data is too late to forward
	assign byp_val = em.result;

	// -----------------------------------------------------------------
	// register write
	// -----------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rstn && em.rd != '0) begin
			regs[em.rd] <= wb_val;
		end
	end

	a_bus_onehot: assert property (@(posedge clk) disable iff (!rstn)
		$onehot0({data_load, data_store}))
		else $error("commit: load and store in one cycle");

	a_natural_align: assert property (@(posedge clk) disable iff (!rstn)
		(data_load || data_store) |->
			(em.funct3[1:0] == 2'b00)
			|| (em.funct3[1:0] == 2'b01 && !em.ls_adrs[0])
			|| (em.funct3[1:0] == 2'b10 && em.ls_adrs[1:0] == 2'b00))
		else $error("commit: misaligned access at %h", em.ls_adrs);

endmodule

/* logic/execute_stage.sv */
// rv32i alu only; jalr clears bit 0, a target with bit 1 set is not trapped and trips an assertion
`timescale 1ns/1ps
`include "rv_defines.svh"

module execute_stage (
	input  logic              clk,
	input  logic              rstn,
	input  rv_pkg::de_pkt_t   de,
	output rv_pkg::redirect_t redir,
	output rv_pkg::em_pkt_t   em
);

	rv_pkg::insn_t   insn;
	rv_pkg::funct3_t f3;
	rv_pkg::word_t   op1;
	rv_pkg::word_t   op2;
	rv_pkg::word_t   imm_i;
	rv_pkg::word_t   imm_s;
	rv_pkg::word_t   imm_b;
	rv_pkg::word_t   imm_j;
	rv_pkg::word_t   imm_u;
	rv_pkg::word_t   alu;
	rv_pkg::word_t   st_data;
	rv_pkg::word_t   result;
	rv_pkg::word_t   target;
	rv_pkg::word_t   ls_adrs;
	logic            cond;
	logic            take;

	assign insn = de.insn;
	assign f3   = de.funct3;
	assign op1  = de.op1;
	assign op2  = de.op2;

	// -----------------------------------------------------------------
	// immediates
	// -----------------------------------------------------------------
	assign imm_i = {{(`RV_XLEN-12){insn[31]}}, insn[31:20]};
	assign imm_s = {{(`RV_XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_b = {{(`RV_XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25],
		insn[11:8], 1'b0};
	assign imm_j = {{(`RV_XLEN-21){insn[31]}}, insn[31], insn[19:12], insn[20],
		insn[30:21], 1'b0};
	assign imm_u = {{(`RV_XLEN-32){insn[31]}}, insn[31:12], 12'h000};

	// -----------------------------------------------------------------
	// alu shared by op and op-imm
	// -----------------------------------------------------------------
	always_comb begin
		case (f3)
			3'b000: alu = (de.cls == rv_pkg::CLS_OP && insn[30]) ? op1 - op2 : op1 + op2;
			3'b001: alu = op1 << op2[4:0];                              // sll
			3'b010: alu = {{(`RV_XLEN-1){1'b0}}, $signed(op1) < $signed(op2)}; // slt
			3'b011: alu = {{(`RV_XLEN-1){1'b0}}, op1 < op2};            // sltu
			3'b100: alu = op1 ^ op2;
			3'b101: alu = insn[30] ? rv_pkg::word_t'($signed(op1) >>> op2[4:0])
				: op1 >> op2[4:0];                                      // sra / srl
			3'b110: alu = op1 | op2;
			default: alu = op1 & op2;
		endcase
	end

	// branch condition from funct3
	always_comb begin
		case (f3)
			3'b000: cond = op1 == op2;
			3'b001: cond = op1 != op2;
			3'b100: cond = $signed(op1) < $signed(op2);
			3'b101: cond = $signed(op1) >= $signed(op2);
			3'b110: cond = op1 < op2;
			3'b111: cond = op1 >= op2;
			default: cond = 1'b0; // reserved encodings never taken
		endcase
	end

	// store value copied into every lane
	always_comb begin
		case (f3[1:0])
			2'b00: st_data = {(`RV_XLEN/8){op2[7:0]}};
			2'b01: st_data = {(`RV_XLEN/16){op2[15:0]}};
			default: st_data = op2;
		endcase
	end

	assign take    = de.cls == rv_pkg::CLS_JAL || de.cls == rv_pkg::CLS_JALR
		|| (de.cls == rv_pkg::CLS_BRANCH && cond);
	assign target  = (de.cls == rv_pkg::CLS_JALR) ? ((op1 + imm_i) & ~rv_pkg::word_t'(1))
		: de.pc + ((de.cls == rv_pkg::CLS_JAL) ? imm_j : imm_b);
	assign ls_adrs = op1 + ((de.cls == rv_pkg::CLS_STORE) ? imm_s : imm_i);

	always_comb begin
		case (de.cls)
			rv_pkg::CLS_LUI:   result = imm_u;
			rv_pkg::CLS_AUIPC: result = de.pc + imm_u;
			rv_pkg::CLS_JAL, rv_pkg::CLS_JALR: result = de.pc4; // link
			rv_pkg::CLS_STORE: result = st_data;
			rv_pkg::CLS_OP, rv_pkg::CLS_OP_IMM: result = alu;
			default: result = '0; // loads take memory data in commit
		endcase
	end

	// -----------------------------------------------------------------
	// stage registers that squash the item behind a taken redirect
	// -----------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rstn || redir.taken) begin
			em.cls      <= rv_pkg::CLS_NONE;
			em.rd       <= '0;
			redir.taken <= 1'b0;
		end else begin
			em.cls       <= de.cls;
			em.rd        <= de.rd;
			em.funct3    <= f3;
			em.result    <= result;
			em.ls_adrs   <= ls_adrs;
			redir.taken  <= take;
			redir.target <= target;
		end
	end

	a_target_aligned: assert property (@(posedge clk) disable iff (!rstn)
		redir.taken |-> redir.target[1:0] == 2'b00)
		else $error("execute: misaligned target %h", redir.target);

endmodule

/* logic/decode_stage.sv */
// stall covers only the load-use and decode-to-execute distances; commit results arrive by bypass
`timescale 1ns/1ps
`include "rv_defines.svh"

module decode_stage (
	input  logic              clk,
	input  logic              rstn,
	input  rv_pkg::fd_pkt_t   fd,
	input  rv_pkg::redirect_t redir,
	output rv_pkg::reg_idx_t  rs1_idx,   // async regfile read
	output rv_pkg::reg_idx_t  rs2_idx,
	input  rv_pkg::word_t     rs1_val,
	input  rv_pkg::word_t     rs2_val,
	input  rv_pkg::reg_idx_t  byp_rd,    // zero when commit offers nothing
	input  rv_pkg::word_t     byp_val,
	input  rv_pkg::reg_idx_t  em_rd,
	input  logic              em_is_load,
	output logic              stall,
	output rv_pkg::de_pkt_t   de
);

	rv_pkg::insn_t    insn;
	logic             use_rs1;
	logic             use_rs2;
	logic             wr_rd;
	logic             hit_rs1;  // rs1 still in flight
	logic             hit_rs2;
	rv_pkg::word_t    imm;
	rv_pkg::word_t    op1;
	rv_pkg::word_t    op2;
	rv_pkg::reg_idx_t rd;

	// x0 first, then the commit bypass, then the register file
	function automatic rv_pkg::word_t pick(input rv_pkg::reg_idx_t idx,
		input rv_pkg::word_t rf_val, input rv_pkg::reg_idx_t b_rd,
		input rv_pkg::word_t b_val);
		if (idx == '0)
			return '0;
		if (idx == b_rd)
			return b_val;
		return rf_val;
	endfunction

	assign insn    = fd.insn;
	assign rs1_idx = insn[19:15];
	assign rs2_idx = insn[24:20];

	// -----------------------------------------------------------------
	// register usage by class
	// -----------------------------------------------------------------
	always_comb begin
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		wr_rd   = 1'b0;
		case (fd.cls)
			rv_pkg::CLS_LOAD, rv_pkg::CLS_OP_IMM, rv_pkg::CLS_JALR: begin
				use_rs1 = 1'b1;
				wr_rd   = 1'b1;
			end
			rv_pkg::CLS_STORE, rv_pkg::CLS_BRANCH: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			rv_pkg::CLS_OP: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				wr_rd   = 1'b1;
			end
			rv_pkg::CLS_AUIPC, rv_pkg::CLS_LUI, rv_pkg::CLS_JAL: wr_rd = 1'b1;
			default: ; // bubble uses nothing
		endcase
	end

	// hazard when the producer sits in execute or a load sits in commit
	assign hit_rs1 = use_rs1 && rs1_idx != '0
		&& (rs1_idx == de.rd || (em_is_load && rs1_idx == em_rd));
	assign hit_rs2 = use_rs2 && rs2_idx != '0
		&& (rs2_idx == de.rd || (em_is_load && rs2_idx == em_rd));
	assign stall   = hit_rs1 || hit_rs2;

	// -----------------------------------------------------------------
	// operands
	// -----------------------------------------------------------------
	assign imm = (insn[13:12] == 2'b01) ? {{(`RV_XLEN-5){1'b0}}, insn[24:20]} // shamt
		: {{(`RV_XLEN-12){insn[31]}}, insn[31:20]};                            // i-type
	assign op1 = pick(rs1_idx, rs1_val, byp_rd, byp_val);
	assign op2 = (fd.cls == rv_pkg::CLS_OP_IMM) ? imm
		: pick(rs2_idx, rs2_val, byp_rd, byp_val);
	assign rd  = wr_rd ? insn[11:7] : '0;

	always_ff @(posedge clk) begin
		if (!rstn || stall || redir.taken) begin
			de.cls <= rv_pkg::CLS_NONE; // bubble
			de.rd  <= '0;
		end else begin
			de.cls    <= fd.cls;
			de.insn   <= insn;
			de.pc     <= fd.pc;
			de.pc4    <= fd.pc4;
			de.rd     <= rd;
			de.funct3 <= insn[14:12];
			de.op1    <= op1;
			de.op2    <= op2;
		end
	end

	// a stall needs a nonzero destination still pending downstream
	a_stall_needs_rd: assert property (@(posedge clk) disable iff (!rstn)
		stall |-> (de.rd != '0) || (em_is_load && em_rd != '0))
		else $error("decode: stall with no pending destination");

endmodule

/* logic/fetch_stage.sv */
// no prediction: every taken redirect squashes two slots; opcodes outside rv32i become bubbles
`timescale 1ns/1ps
`include "rv_defines.svh"

module fetch_stage (
	input  logic              clk,
	input  logic              rstn,
	input  logic              stall,      // decode holds its source item
	input  rv_pkg::redirect_t redir,      // registered in execute
	input  rv_pkg::insn_t     insn_rdata, // same cycle as insn_adrs
	output rv_pkg::word_t     insn_adrs,
	output rv_pkg::fd_pkt_t   fd
);

	rv_pkg::word_t next_pc;  // sequential address
	rv_pkg::word_t pc_plus4;

	// -----------------------------------------------------------------
	// opcode classification
	// -----------------------------------------------------------------
	function automatic rv_pkg::insn_class_e classify(input rv_pkg::insn_t insn);
		case (insn[6:0])
			`RV_OPC_LOAD:   return rv_pkg::CLS_LOAD;
			`RV_OPC_OP_IMM: return rv_pkg::CLS_OP_IMM;
			`RV_OPC_AUIPC:  return rv_pkg::CLS_AUIPC;
			`RV_OPC_STORE:  return rv_pkg::CLS_STORE;
			`RV_OPC_OP:     return rv_pkg::CLS_OP;
			`RV_OPC_LUI:    return rv_pkg::CLS_LUI;
			`RV_OPC_BRANCH: return rv_pkg::CLS_BRANCH;
			`RV_OPC_JALR:   return rv_pkg::CLS_JALR;
			`RV_OPC_JAL:    return rv_pkg::CLS_JAL;
			default:        return rv_pkg::CLS_NONE; // system, fence, custom
		endcase
	endfunction

	// redirect wins over the sequential pc
	assign insn_adrs = redir.taken ? redir.target : next_pc;
	assign pc_plus4  = insn_adrs + `RV_XLEN'(4);

	// -----------------------------------------------------------------
	// capture
	// -----------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rstn) begin
			next_pc <= `RV_RESET_ADDR;
			fd.cls  <= rv_pkg::CLS_NONE; // payload left as is
		end else if (!stall || redir.taken) begin
			next_pc <= pc_plus4;
			fd.cls  <= classify(insn_rdata);
			fd.insn <= insn_rdata;
			fd.pc   <= insn_adrs;
			fd.pc4  <= pc_plus4;
		end
	end

	// covers both the sequential path and every branch or jump target
	a_fetch_aligned: assert property (@(posedge clk) disable iff (!rstn)
		insn_adrs[1:0] == 2'b00)
		else $error("fetch: misaligned insn_adrs %h", insn_adrs);

endmodule

/* logic/rv_pkg.sv */
// types shared by the pipeline stages; packets carry no valid bit, CLS_NONE is a bubble
`include "rv_defines.svh"

package rv_pkg;

	// -----------------------------------------------------------------
	// plain vectors
	// -----------------------------------------------------------------
	typedef logic [`RV_XLEN-1:0]   word_t;    // data or address
	typedef logic [31:0]           insn_t;    // raw instruction
	typedef logic [4:0]            reg_idx_t; // x0..x31
	typedef logic [2:0]            funct3_t;  // minor opcode
	typedef logic [`RV_XLEN/8-1:0] strb_t;    // byte write enables

	// instruction class, set once in fetch
	typedef enum logic [3:0] {
		CLS_NONE,   // bubble or unknown opcode
		CLS_LOAD,
		CLS_OP_IMM,
		CLS_AUIPC,
		CLS_STORE,
		CLS_OP,
		CLS_LUI,
		CLS_BRANCH,
		CLS_JALR,
		CLS_JAL
	} insn_class_e;

	// -----------------------------------------------------------------
	// stage packets
	// -----------------------------------------------------------------
	typedef struct packed {
		insn_class_e cls;
		insn_t       insn;
		word_t       pc;
		word_t       pc4;  // link value and sequential next
	} fd_pkt_t;

	typedef struct packed {
		insn_class_e cls;
		insn_t       insn; // immediates extracted in execute
		word_t       pc;
		word_t       pc4;
		reg_idx_t    rd;   // zero when nothing is written
		funct3_t     funct3;
		word_t       op1;
		word_t       op2;  // immediate for op-imm
	} de_pkt_t;

	typedef struct packed {
		insn_class_e cls;
		reg_idx_t    rd;
		funct3_t     funct3;
		word_t       result;  // alu value, link or store data
		word_t       ls_adrs; // load/store byte address
	} em_pkt_t;

	typedef struct packed {
		logic  taken;
		word_t target;
	} redirect_t;

endpackage

/* logic/rv_defines.svh */
// rv32i base set only; widths other than 32 are not supported by the stage logic
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// ---------------------------------------------------------------------
// machine sizes
// ---------------------------------------------------------------------
`define RV_XLEN       32            // data and address width
`define RV_RESET_ADDR 32'h0000_0000 // first fetch after rstn
`define RV_NREGS      32            // x0..x31, x0 reads zero

// ---------------------------------------------------------------------
// major opcodes, insn[6:0]
// ---------------------------------------------------------------------
`define RV_OPC_LOAD   7'b0000011 // lb lh lw lbu lhu
`define RV_OPC_OP_IMM 7'b0010011 // addi slti ... srai
`define RV_OPC_AUIPC  7'b0010111
`define RV_OPC_STORE  7'b0100011 // sb sh sw
`define RV_OPC_OP     7'b0110011 // register-register alu
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_BRANCH 7'b1100011 // beq .. bgeu
`define RV_OPC_JALR   7'b1100111
`define RV_OPC_JAL    7'b1101111

`endif
